/* hw/ft_macros.svh */
`ifndef FT_MACROS_SVH
`define FT_MACROS_SVH

// ==================================================
// FT245 FIFO strobe timing, in clk cycles
// ==================================================

// Read cycle counter marks
`define FT_RD_STROBE_START 2
`define FT_RD_SAMPLE       9
`define FT_RD_STROBE_STOP  12
`define FT_RD_CYCLE_END    25

// Write cycle counter marks
`define FT_WR_STROBE_START 5
`define FT_WR_STROBE_STOP  15
`define FT_WR_CYCLE_END    25

// ==================================================
// Packet framing
// ==================================================

`define PKT_HEADER_SYMBOL  8'h55
`define PKT_HEADER_COUNT   12
`define PKT_TRAILER_SYMBOL 8'hAA
`define PKT_TRAILER_COUNT  8
`define PKT_ERROR_SYMBOL   8'hEE
// Length and service fields plus trailer
`define PKT_MIN_LENGTH     12

// Payload storage
`define PKT_RAM_WORDS      2048

`endif

/* hw/ft_pkg.sv */
package ft_pkg;

	`include "ft_macros.svh"

	// One byte on the FIFO data bus
	typedef logic [7:0] ft_byte_t;

	// Length, service type or payload word
	typedef logic [15:0] ft_word_t;

	// Word address into payload RAM
	// Width follows RAM depth
	typedef logic [$clog2(`PKT_RAM_WORDS)-1:0] ram_addr_t;

endpackage

/* hw/ft_rd_cycle.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module ft_rd_cycle import ft_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     rxf_n,
	input  ft_byte_t din,
	output logic     rd_n,
	output logic     rx_valid,
	output ft_byte_t rx_byte,
	output logic     rd_active
);

	// rxf_n synchronizer plus edge history
	logic rxf_meta;
	logic rxf_sync;
	logic rxf_prev;
	logic rxf_fall;
	// Edge seen while a cycle was still running
	logic rd_pend;
	logic rd_start;
	logic [4:0] rd_cnt;
	logic rd_strobe;

	// ==================================================
	// Data-ready detection
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rxf_meta <= 1'b1;
			rxf_sync <= 1'b1;
			rxf_prev <= 1'b1;
		end else begin
			rxf_meta <= rxf_n;
			rxf_sync <= rxf_meta;
			rxf_prev <= rxf_sync;
		end
	end

	// FIFO has a byte once rxf_n drops
	assign rxf_fall = rxf_prev & ~rxf_sync;
	assign rd_start = ~rd_active & (rxf_fall | rd_pend);

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_pend <= 1'b0;
		end else if (rd_start) begin
			rd_pend <= 1'b0;
		end else if (rxf_fall) begin
			rd_pend <= 1'b1;
		end
	end

	// ==================================================
	// Read cycle timing
	// ==================================================

	// Counter runs 0..END, 26 cycles per byte
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_active <= 1'b0;
			rd_cnt <= '0;
		end else if (rd_start) begin
			rd_active <= 1'b1;
			rd_cnt <= '0;
		end else if (rd_active) begin
			if (rd_cnt == 5'(`FT_RD_CYCLE_END)) begin
				rd_active <= 1'b0;
				rd_cnt <= '0;
			end else begin
				rd_cnt <= rd_cnt + 5'd1;
			end
		end
	end

	// Read strobe window
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_strobe <= 1'b0;
		end else if (rd_active && rd_cnt == 5'(`FT_RD_STROBE_START)) begin
			rd_strobe <= 1'b1;
		end else if (rd_cnt == 5'(`FT_RD_STROBE_STOP)) begin
			rd_strobe <= 1'b0;
		end
	end

	assign rd_n = ~rd_strobe;

	// Data is stable well inside the strobe
	always_ff @(posedge clk) begin
		if (rd_active && rd_cnt == 5'(`FT_RD_SAMPLE)) begin
			rx_byte <= din;
		end
	end

	// One pulse, the cycle after sampling
	assign rx_valid = rd_active && (rd_cnt == 5'(`FT_RD_SAMPLE + 1));

endmodule

/* hw/ft_wr_cycle.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module ft_wr_cycle import ft_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     txe_n,
	input  logic     tx_valid,
	input  ft_byte_t tx_byte,
	output logic     tx_ready,
	output logic     wr,
	output ft_byte_t dout,
	output logic     wr_active
);

	// txe_n synchronizer, high means FIFO full
	logic txe_meta;
	logic txe_sync;
	logic tx_accept;
	logic wr_hold;
	logic [4:0] wr_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			txe_meta <= 1'b1;
			txe_sync <= 1'b1;
		end else begin
			txe_meta <= txe_n;
			txe_sync <= txe_meta;
		end
	end

	// ==================================================
	// Byte handshake
	// ==================================================

	// Idle and room in the FIFO
	assign tx_ready = ~wr_active & ~txe_sync;
	assign tx_accept = tx_valid & tx_ready;

	// Byte held on the bus for the whole cycle
	always_ff @(posedge clk) begin
		if (tx_accept) begin
			dout <= tx_byte;
		end
	end

	// ==================================================
	// Write cycle timing
	// ==================================================

	// Strobe start waits while the FIFO reports full
	assign wr_hold = (wr_cnt == 5'(`FT_WR_STROBE_START)) & txe_sync;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_active <= 1'b0;
			wr_cnt <= '0;
		end else if (tx_accept) begin
			wr_active <= 1'b1;
			wr_cnt <= '0;
		end else if (wr_active) begin
			if (wr_cnt == 5'(`FT_WR_CYCLE_END)) begin
				wr_active <= 1'b0;
				wr_cnt <= '0;
			end else if (!wr_hold) begin
				wr_cnt <= wr_cnt + 5'd1;
			end
		end
	end

	// FIFO latches dout on the falling edge of wr
	always_ff @(posedge clk) begin
		if (rst) begin
			wr <= 1'b0;
		end else if (wr_active && wr_cnt == 5'(`FT_WR_STROBE_START) && !txe_sync) begin
			wr <= 1'b1;
		end else if (wr_cnt == 5'(`FT_WR_STROBE_STOP)) begin
			wr <= 1'b0;
		end
	end

endmodule

/* hw/pkt_rx_parser.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module pkt_rx_parser import ft_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      rx_valid,
	input  ft_byte_t  rx_byte,
	output logic      ram_we,
	output ram_addr_t ram_waddr,
	output ft_word_t  ram_wdata,
	output logic      pkt_active,
	output logic      pkt_error,
	output logic      pkt_done,
	output logic      pkt_ok,
	output ft_word_t  pkt_length,
	output ft_word_t  pkt_service
);

	// Consecutive symbol counters
	logic [3:0] hdr_cnt;
	logic [3:0] trl_cnt;
	// Byte index after the header, 0 is length low
	ft_word_t byte_idx;
	// Payload byte offset
	ft_word_t pay_idx;
	// End of payload area
	ft_word_t pay_end;
	// Even payload byte waiting for its partner
	ft_byte_t low_byte;
	logic body_byte;
	logic hdr_hit;
	logic trl_last;
	logic len_err;
	logic short_err;
	logic err_now;
	logic end_ok;
	logic in_pkt;

	assign in_pkt = rx_valid & pkt_active;

	// ==================================================
	// Header search
	// ==================================================

	assign hdr_hit = rx_valid & ~pkt_active & (rx_byte == `PKT_HEADER_SYMBOL)
		& (hdr_cnt == 4'(`PKT_HEADER_COUNT - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			hdr_cnt <= '0;
		end else if (rx_valid && !pkt_active) begin
			// Any other byte restarts the run
			if (rx_byte != `PKT_HEADER_SYMBOL || hdr_hit) begin
				hdr_cnt <= '0;
			end else begin
				hdr_cnt <= hdr_cnt + 4'd1;
			end
		end
	end

	// ==================================================
	// End and error detection
	// ==================================================

	// Past length and service fields
	assign body_byte = byte_idx >= 16'd4;
	assign pay_idx = byte_idx - 16'd4;
	assign pay_end = pkt_length - 16'(`PKT_TRAILER_COUNT);

	assign trl_last = in_pkt & body_byte & (rx_byte == `PKT_TRAILER_SYMBOL)
		& (trl_cnt == 4'(`PKT_TRAILER_COUNT - 1));

	// Length complete from index 2 on
	assign len_err = in_pkt & (byte_idx >= 16'd2)
		& ((pkt_length < 16'(`PKT_MIN_LENGTH)) | (byte_idx >= pkt_length));

	// Trailer came before the declared length ran out
	assign short_err = trl_last & (byte_idx != pkt_length - 16'd1);

	assign err_now = len_err | short_err;
	assign end_ok = trl_last & ~err_now;

	always_ff @(posedge clk) begin
		if (rst) begin
			pkt_active <= 1'b0;
			byte_idx <= '0;
			trl_cnt <= '0;
		end else if (hdr_hit) begin
			pkt_active <= 1'b1;
			byte_idx <= '0;
			trl_cnt <= '0;
		end else if (in_pkt) begin
			if (err_now || end_ok) begin
				pkt_active <= 1'b0;
			end
			byte_idx <= byte_idx + 16'd1;
			if (body_byte && rx_byte == `PKT_TRAILER_SYMBOL) begin
				trl_cnt <= trl_cnt + 4'd1;
			end else begin
				trl_cnt <= '0;
			end
		end
	end

	// Status pulses, one cycle after the deciding byte
	always_ff @(posedge clk) begin
		if (rst) begin
			pkt_done <= 1'b0;
			pkt_ok <= 1'b0;
			pkt_error <= 1'b0;
		end else begin
			pkt_done <= err_now | end_ok;
			pkt_ok <= end_ok;
			pkt_error <= err_now;
		end
	end

	// ==================================================
	// Field capture
	// ==================================================

	// Fields stay put until the next packet overwrites them
	always_ff @(posedge clk) begin
		if (in_pkt) begin
			case (byte_idx)
				16'd0: pkt_length[7:0] <= rx_byte;
				16'd1: pkt_length[15:8] <= rx_byte;
				16'd2: pkt_service[7:0] <= rx_byte;
				16'd3: pkt_service[15:8] <= rx_byte;
				default: begin
					if (!byte_idx[0]) begin
						low_byte <= rx_byte;
					end
				end
			endcase
		end
	end

	// Odd byte completes a little-endian word
	assign ram_we = in_pkt & body_byte & byte_idx[0] & (byte_idx < pay_end) & ~err_now;
	assign ram_waddr = pay_idx[11:1];
	assign ram_wdata = {rx_byte, low_byte};

endmodule

/* hw/pkt_ram.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module pkt_ram import ft_pkg::*; (
	input  logic      clk,
	input  logic      we,
	input  ram_addr_t waddr,
	input  ft_word_t  wdata,
	input  ram_addr_t raddr,
	output ft_word_t  rdata
);

	// Payload words of the last packet
	ft_word_t mem [`PKT_RAM_WORDS];

	// Write port, parser side
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read port, framer side
	// Data one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

/* hw/pkt_tx_framer.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module pkt_tx_framer import ft_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      pkt_done,
	input  logic      pkt_ok,
	input  ft_word_t  pkt_length,
	input  ft_word_t  pkt_service,
	output ram_addr_t ram_raddr,
	input  ft_word_t  ram_rdata,
	output logic      tx_valid,
	output ft_byte_t  tx_byte,
	input  logic      tx_ready
);

	// Valid echo or error reply
	logic reply_ok;
	// Index of the byte on offer
	ft_word_t tx_cnt;
	ft_word_t tx_nxt;
	// First payload byte sits after header, length, service
	localparam int PAY_START = `PKT_HEADER_COUNT + 4;
	ft_word_t trl_start;
	ft_word_t last_idx;
	ft_word_t cur_off;
	ft_word_t nxt_off;
	logic advance;
	logic last_byte;

	// ==================================================
	// Reply sequencing
	// ==================================================

	assign advance = tx_valid & tx_ready;

	// Error reply carries no payload
	assign trl_start = reply_ok
		? 16'(`PKT_HEADER_COUNT) + pkt_length - 16'(`PKT_TRAILER_COUNT)
		: 16'(PAY_START);
	assign last_idx = trl_start + 16'(`PKT_TRAILER_COUNT - 1);
	assign last_byte = tx_cnt == last_idx;

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_valid <= 1'b0;
			tx_cnt <= '0;
			reply_ok <= 1'b0;
		end else if (pkt_done) begin
			tx_valid <= 1'b1;
			tx_cnt <= '0;
			reply_ok <= pkt_ok;
		end else if (advance) begin
			if (last_byte) begin
				tx_valid <= 1'b0;
			end
			tx_cnt <= tx_nxt;
		end
	end

	// ==================================================
	// Payload prefetch
	// ==================================================

	// Address follows the byte about to be offered
	// so the word is out of RAM when its turn comes
	assign tx_nxt = advance ? tx_cnt + 16'd1 : tx_cnt;
	assign nxt_off = tx_nxt - 16'(PAY_START);
	assign ram_raddr = nxt_off[11:1];

	// Even offset is the low byte
	assign cur_off = tx_cnt - 16'(PAY_START);

	// ==================================================
	// Reply byte mux
	// ==================================================

	always_comb begin
		if (tx_cnt < 16'(`PKT_HEADER_COUNT)) begin
			tx_byte = `PKT_HEADER_SYMBOL;
		end else if (tx_cnt == 16'(`PKT_HEADER_COUNT)) begin
			tx_byte = pkt_length[7:0];
		end else if (tx_cnt == 16'(`PKT_HEADER_COUNT + 1)) begin
			tx_byte = pkt_length[15:8];
		end else if (tx_cnt == 16'(`PKT_HEADER_COUNT + 2)) begin
			tx_byte = reply_ok ? pkt_service[7:0] : `PKT_ERROR_SYMBOL;
		end else if (tx_cnt == 16'(`PKT_HEADER_COUNT + 3)) begin
			tx_byte = reply_ok ? pkt_service[15:8] : `PKT_ERROR_SYMBOL;
		end else if (tx_cnt < trl_start) begin
			tx_byte = cur_off[0] ? ram_rdata[15:8] : ram_rdata[7:0];
		end else begin
			tx_byte = `PKT_TRAILER_SYMBOL;
		end
	end

endmodule

/* hw/ft_packet_top.sv */
`timescale 1ns/1ps

module ft_packet_top import ft_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     rxf_n,
	input  ft_byte_t din,
	output logic     rd_n,
	input  logic     txe_n,
	output logic     wr,
	output ft_byte_t dout,
	output logic     busy,
	output logic     pkt_active,
	output logic     pkt_error
);

	// Receive side
	logic      rx_valid;
	ft_byte_t  rx_byte;
	logic      rd_active;
	// Payload RAM
	logic      ram_we;
	ram_addr_t ram_waddr;
	ft_word_t  ram_wdata;
	ram_addr_t ram_raddr;
	ft_word_t  ram_rdata;
	// Packet status toward framer
	logic      pkt_done;
	logic      pkt_ok;
	ft_word_t  pkt_length;
	ft_word_t  pkt_service;
	// Reply stream
	logic      tx_valid;
	ft_byte_t  tx_byte;
	logic      tx_ready;
	logic      wr_active;

	// ==================================================
	// FIFO read, parse, store
	// ==================================================

	ft_rd_cycle i_ft_rd_cycle (
		.clk       (clk),
		.rst       (rst),
		.rxf_n     (rxf_n),
		.din       (din),
		.rd_n      (rd_n),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.rd_active (rd_active)
	);

	pkt_rx_parser i_pkt_rx_parser (
		.clk         (clk),
		.rst         (rst),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.ram_we      (ram_we),
		.ram_waddr   (ram_waddr),
		.ram_wdata   (ram_wdata),
		.pkt_active  (pkt_active),
		.pkt_error   (pkt_error),
		.pkt_done    (pkt_done),
		.pkt_ok      (pkt_ok),
		.pkt_length  (pkt_length),
		.pkt_service (pkt_service)
	);

	pkt_ram i_pkt_ram (
		.clk   (clk),
		.we    (ram_we),
		.waddr (ram_waddr),
		.wdata (ram_wdata),
		.raddr (ram_raddr),
		.rdata (ram_rdata)
	);

	// ==================================================
	// Reply build and FIFO write
	// ==================================================

	pkt_tx_framer i_pkt_tx_framer (
		.clk         (clk),
		.rst         (rst),
		.pkt_done    (pkt_done),
		.pkt_ok      (pkt_ok),
		.pkt_length  (pkt_length),
		.pkt_service (pkt_service),
		.ram_raddr   (ram_raddr),
		.ram_rdata   (ram_rdata),
		.tx_valid    (tx_valid),
		.tx_byte     (tx_byte),
		.tx_ready    (tx_ready)
	);

	ft_wr_cycle i_ft_wr_cycle (
		.clk       (clk),
		.rst       (rst),
		.txe_n     (txe_n),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready),
		.wr        (wr),
		.dout      (dout),
		.wr_active (wr_active)
	);

	// FIFO bus in use either way
	assign busy = rd_active | wr_active;

endmodule

/* tests/tb_ft_packet.sv */
`timescale 1ns/1ps

`include "ft_macros.svh"

module tb_ft_packet import ft_pkg::*; ();

	typedef ft_byte_t byte_q_t [$];

	// Budget for about six packets of up to 60 bytes each way
	// at roughly 40 cycles per byte, plus margin
	localparam int unsigned CYCLE_LIMIT = 60000;

	logic     clk = 1'b0;
	logic     rst;
	logic     rxf_n;
	ft_byte_t din;
	logic     rd_n;
	logic     txe_n;
	logic     wr;
	ft_byte_t dout;
	logic     busy;
	logic     pkt_active;
	logic     pkt_error;

	// Reply bytes still owed by the DUT, oldest first
	byte_q_t exp_q;
	// Full length of the reply now being checked
	int unsigned reply_len = 0;
	int unsigned cycle_cnt = 0;
	int unsigned txe_high_cycles = 0;
	int unsigned txe_stall_cycles = 0;
	int unsigned error_pulses = 0;
	int unsigned reply_bytes = 0;
	logic wr_q = 1'b0;
	// Random back-pressure on txe_n
	logic txe_toggle;

	ft_packet_top i_ft_packet_top (
		.clk        (clk),
		.rst        (rst),
		.rxf_n      (rxf_n),
		.din        (din),
		.rd_n       (rd_n),
		.txe_n      (txe_n),
		.wr         (wr),
		.dout       (dout),
		.busy       (busy),
		.pkt_active (pkt_active),
		.pkt_error  (pkt_error)
	);

	always #20 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	// ==================================================
	// Packet and reply construction
	// ==================================================

	// Payload bytes never look like frame symbols
	function automatic byte_q_t random_payload(input int unsigned nbytes);
		byte_q_t pay;
		ft_byte_t b;
		pay = {};
		for (int unsigned i = 0; i < nbytes; i++) begin
			b = 8'($urandom);
			while (b == `PKT_HEADER_SYMBOL || b == `PKT_TRAILER_SYMBOL) begin
				b = 8'($urandom);
			end
			pay.push_back(b);
		end
		return pay;
	endfunction

	function automatic byte_q_t build_packet(input ft_word_t length, input ft_word_t service,
			input byte_q_t pay);
		byte_q_t pkt;
		pkt = {};
		repeat (`PKT_HEADER_COUNT) pkt.push_back(`PKT_HEADER_SYMBOL);
		// Length and service go low byte first
		pkt.push_back(length[7:0]);
		pkt.push_back(length[15:8]);
		pkt.push_back(service[7:0]);
		pkt.push_back(service[15:8]);
		foreach (pay[i]) pkt.push_back(pay[i]);
		repeat (`PKT_TRAILER_COUNT) pkt.push_back(`PKT_TRAILER_SYMBOL);
		return pkt;
	endfunction

	// Reference model of the reply
	// Valid packet echoes fields and payload
	// Error reply swaps in EE EE for the service field
	function automatic byte_q_t expected_reply(input byte_q_t pkt, input bit ok);
		byte_q_t rep;
		int pay_end;
		rep = {};
		repeat (`PKT_HEADER_COUNT) rep.push_back(`PKT_HEADER_SYMBOL);
		rep.push_back(pkt[`PKT_HEADER_COUNT]);
		rep.push_back(pkt[`PKT_HEADER_COUNT + 1]);
		if (ok) begin
			rep.push_back(pkt[`PKT_HEADER_COUNT + 2]);
			rep.push_back(pkt[`PKT_HEADER_COUNT + 3]);
			// Payload sits between the service field and the trailer
			pay_end = pkt.size() - `PKT_TRAILER_COUNT;
			for (int i = `PKT_HEADER_COUNT + 4; i < pay_end; i++) begin
				rep.push_back(pkt[i]);
			end
		end else begin
			rep.push_back(`PKT_ERROR_SYMBOL);
			rep.push_back(`PKT_ERROR_SYMBOL);
		end
		repeat (`PKT_TRAILER_COUNT) rep.push_back(`PKT_TRAILER_SYMBOL);
		return rep;
	endfunction

	// ==================================================
	// Host side of the FIFO
	// ==================================================

	// Hold rxf_n low for one byte until the read strobe finishes
	task automatic send_byte(input ft_byte_t value);
		@(negedge clk);
		din = value;
		rxf_n = 1'b0;
		while (rd_n !== 1'b0) @(negedge clk);
		while (rd_n !== 1'b1) @(negedge clk);
		rxf_n = 1'b1;
		repeat (3) @(negedge clk);
	endtask

	// pkt_active tracked from the last header byte up to the last trailer byte
	task automatic send_packet(input byte_q_t pkt, input bit watch_active);
		logic want;
		for (int i = 0; i < pkt.size(); i++) begin
			send_byte(pkt[i]);
			want = (i >= `PKT_HEADER_COUNT - 1) && (i < pkt.size() - 1);
			if (watch_active) begin
				assert (pkt_active === want) else stop_on_error($sformatf(
					"Error at %0t ns: pkt_active is %b after packet byte %0d, expected %b",
					$time, pkt_active, i, want));
			end
		end
	endtask

	task automatic wait_reply_done();
		while (exp_q.size() != 0) @(negedge clk);
		while (busy !== 1'b0) @(negedge clk);
		repeat (20) @(negedge clk);
	endtask

	task automatic run_case(input string name, input byte_q_t pkt, input bit ok);
		byte_q_t want;
		int unsigned pulses_want;
		want = expected_reply(pkt, ok);
		pulses_want = ok ? error_pulses : error_pulses + 1;
		reply_len = want.size();
		exp_q = want;
		send_packet(pkt, ok);
		wait_reply_done();
		assert (error_pulses == pulses_want) else stop_on_error($sformatf(
			"Error at %0t ns: %s saw %0d pkt_error pulses, expected %0d",
			$time, name, error_pulses, pulses_want));
		$display("%s: %0d reply bytes compared", name, want.size());
	endtask

	// ==================================================
	// Reply monitor and compare
	// ==================================================

	// wr and dout are settled at the falling edge
	always @(negedge clk) begin
		if (pkt_error === 1'b1) begin
			error_pulses++;
		end
		if (wr === 1'b1 && wr_q === 1'b0) begin
			check_reply_byte(dout);
		end
		wr_q = wr;
	end

	task automatic check_reply_byte(input ft_byte_t got);
		ft_byte_t want;
		assert (exp_q.size() != 0) else stop_on_error(
			"The DUT wrote a byte to the FIFO although no reply byte was expected");
		want = exp_q.pop_front();
		assert (got === want) else stop_on_error($sformatf(
			"Error at %0t ns: reply byte %0d is %02h, expected %02h",
			$time, reply_bytes, got, want));
		// FIFO full for longer than the sync delay must block the strobe
		assert (txe_high_cycles <= 3) else stop_on_error($sformatf(
			"Error at %0t ns: wr rose after txe_n was high for %0d cycles",
			$time, txe_high_cycles));
		reply_bytes++;
	endtask

	// Cycle count, txe_n history, watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (txe_n) begin
			txe_high_cycles++;
			// Only stalls that land inside a reply already under way
			if (exp_q.size() != 0 && exp_q.size() < reply_len) begin
				txe_stall_cycles++;
			end
		end else begin
			txe_high_cycles = 0;
		end
		if (cycle_cnt >= CYCLE_LIMIT) begin
			stop_on_error($sformatf("The simulation timed out after %0d cycles", cycle_cnt));
		end
	end

	// Only driver of txe_n
	initial begin
		int unsigned span;
		txe_n = 1'b0;
		forever begin
			@(negedge clk);
			if (txe_toggle) begin
				span = 4 + ($urandom % 30);
				repeat (span) @(negedge clk);
				txe_n = 1'b1;
				span = 1 + ($urandom % 12);
				repeat (span) @(negedge clk);
				txe_n = 1'b0;
			end
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		byte_q_t pkt;
		byte_q_t pay;
		int unsigned nbytes;
		int unsigned stall_before;
		void'($urandom(32'hd38b96e2));
		rst = 1'b1;
		rxf_n = 1'b1;
		din = 8'h00;
		txe_toggle = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// Idle state after reset
		assert (rd_n === 1'b1 && wr === 1'b0 && busy === 1'b0) else stop_on_error($sformatf(
			"Error at %0t ns: idle bus rd_n=%b wr=%b busy=%b after reset",
			$time, rd_n, wr, busy));
		assert (pkt_active === 1'b0 && pkt_error === 1'b0) else stop_on_error($sformatf(
			"Error at %0t ns: pkt_active=%b pkt_error=%b after reset",
			$time, pkt_active, pkt_error));
		// Monitor flags any stray wr pulse here
		repeat (200) @(negedge clk);

		// Shortest valid packet
		pay = {};
		pkt = build_packet(16'd12, 16'h1234, pay);
		run_case("empty payload", pkt, 1'b1);

		// Random echoes
		for (int n = 0; n < 3; n++) begin
			nbytes = 2 * (1 + ($urandom % 20));
			pay = random_payload(nbytes);
			pkt = build_packet(16'(12 + nbytes), 16'($urandom), pay);
			run_case($sformatf("echo %0d, %0d payload bytes", n, nbytes), pkt, 1'b1);
		end

		// Declared length too small, then recovery
		pay = {};
		pkt = build_packet(16'd6, 16'h0102, pay);
		run_case("length 6", pkt, 1'b0);
		pay = random_payload(8);
		pkt = build_packet(16'd20, 16'h4321, pay);
		run_case("echo after error", pkt, 1'b1);

		// Trailer runs past the declared length
		pay = random_payload(6);
		pkt = build_packet(16'd14, 16'h0a0b, pay);
		run_case("length 14 with 6 payload bytes", pkt, 1'b0);

		// Back-pressure during a valid reply
		stall_before = txe_stall_cycles;
		txe_toggle = 1'b1;
		pay = random_payload(10);
		pkt = build_packet(16'd22, 16'($urandom), pay);
		run_case("echo under back-pressure", pkt, 1'b1);
		txe_toggle = 1'b0;
		assert (txe_stall_cycles > stall_before) else stop_on_error(
			"txe_n was never held high during the back-pressure reply");

		repeat (50) @(negedge clk);
		// Both FIFO engines and the parser back at rest
		if (busy === 1'b0 && wr === 1'b0 && rd_n === 1'b1 && pkt_active === 1'b0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_on_error($sformatf(
				"Error at %0t ns: DUT not idle at the end, busy=%b wr=%b rd_n=%b pkt_active=%b",
				$time, busy, wr, rd_n, pkt_active));
		end
	end

endmodule

/* compile.f */
+incdir+hw
hw/ft_pkg.sv
hw/ft_rd_cycle.sv
hw/ft_wr_cycle.sv
hw/pkt_rx_parser.sv
hw/pkt_ram.sv
hw/pkt_tx_framer.sv
hw/ft_packet_top.sv
tests/tb_ft_packet.sv

/* run.sh */
#!/bin/sh
# Build and run the packet engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ft_packet -f compile.f -o sim_tb \
	|| { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/sim_tb 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***' \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
